// File: build.f
common/rv_pkg.sv
ex/ex_control.sv
ex/ex_branch_unit.sv
ex/ex_datapath.sv
hdl/ex_stage.sv
testbench/ex_stage_assertions.sv
testbench/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the EX stage testbench with Verilator.
# The result is taken from the pass message in sim.log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module ex_stage_tb -f build.f \
    -o ex_stage_sim > build.log 2>&1 \
    && ./obj_dir/ex_stage_sim +verilator+error+limit+100 > sim.log 2>&1

grep -q "^Testbench passed$" sim.log \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED, see build.log and sim.log"; exit 1; }

// File: testbench/ex_stage_tb.sv
`default_nettype none

module ex_stage_tb;

    import rv_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int SWEEP_LEN  = 200;

    typedef struct packed {
        id_ex_t      id_ex;
        fwd_src_t    mem_fwd;
        fwd_src_t    wb_fwd;
        logic        stall;
        logic        redirect;
        logic [31:0] redirect_pc;
        logic [31:0] result;
        logic [31:0] store_data;
    } vector_t;

    logic        clk;
    logic        rst;
    id_ex_t      id_ex;
    fwd_src_t    mem_fwd;
    fwd_src_t    wb_fwd;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        flush;
    ex_mem_t     ex_mem;

    vector_t     table_q[$];
    logic        table_built;
    logic [31:0] lcg_state;
    int          errors;
    int          checks;

    ex_stage dut_i (
        .clk         (clk),
        .rst         (rst),
        .id_ex       (id_ex),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_fwd),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .flush       (flush),
        .ex_mem      (ex_mem)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] encode(input logic [4:0] opc, input logic [4:0] rd,
                                           input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [6:0] f7);
        return {f7, rs2, rs1, f3, rd, opc, 2'b11};
    endfunction

    // RV32I arithmetic semantics; alt is instruction bit 30
    function automatic logic [31:0] model_alu(input logic is_imm, input logic [2:0] f3,
                                              input logic alt, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000: begin
                if (alt && !is_imm) begin
                    return a - b;
                end
                return a + b;
            end
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic vector_t make_vec(input logic valid, input logic [31:0] inst,
                                         input logic [31:0] pc, input logic [31:0] rs1_data,
                                         input logic [31:0] rs2_data, input logic [31:0] imm,
                                         input logic pred, input fwd_src_t mem,
                                         input fwd_src_t wb, input logic exp_stall,
                                         input logic exp_redirect, input logic [31:0] exp_pc,
                                         input logic [31:0] exp_result,
                                         input logic [31:0] exp_store);
        vector_t v;
        v.id_ex.valid      = valid;
        v.id_ex.inst       = inst;
        v.id_ex.pc         = pc;
        v.id_ex.rs1_data   = rs1_data;
        v.id_ex.rs2_data   = rs2_data;
        v.id_ex.imm        = imm;
        v.id_ex.pred_taken = pred;
        v.mem_fwd          = mem;
        v.wb_fwd           = wb;
        v.stall            = exp_stall;
        v.redirect         = exp_redirect;
        v.redirect_pc      = exp_pc;
        v.result           = exp_result;
        v.store_data       = exp_store;
        return v;
    endfunction

    task automatic add_entry(input logic valid, input logic [31:0] inst, input logic [31:0] pc,
                             input logic [31:0] rs1_data, input logic [31:0] rs2_data,
                             input logic [31:0] imm, input logic pred, input fwd_src_t mem,
                             input fwd_src_t wb, input logic exp_stall, input logic exp_redirect,
                             input logic [31:0] exp_pc, input logic [31:0] exp_result,
                             input logic [31:0] exp_store);
        table_q.push_back(make_vec(valid, inst, pc, rs1_data, rs2_data, imm, pred, mem, wb,
                                   exp_stall, exp_redirect, exp_pc, exp_result, exp_store));
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL time=%0t %s: actual %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic build_table();
        logic [31:0] add3;
        logic [31:0] add3_x0;
        logic [31:0] addi3;
        logic [31:0] wr0;
        logic [31:0] wr1;
        logic [31:0] wr2;
        logic [31:0] lw1;
        logic [31:0] lw2;
        logic [31:0] lw4;
        logic [31:0] sw;
        logic [31:0] lui;
        logic [31:0] auipc;
        logic [31:0] jal;
        logic [31:0] jalr;
        logic [31:0] beq;
        logic [31:0] bne;
        logic [31:0] blt;
        logic [31:0] bge;
        logic [31:0] bltu;
        logic [31:0] bgeu;
        add3    = encode(OPC_RTYPE, 5'd3, 3'b000, 5'd1, 5'd2, 7'd0);
        add3_x0 = encode(OPC_RTYPE, 5'd3, 3'b000, 5'd0, 5'd2, 7'd0);
        addi3   = encode(OPC_ITYPE, 5'd3, 3'b000, 5'd1, 5'd5, 7'd0);
        wr0     = encode(OPC_RTYPE, 5'd0, 3'b000, 5'd0, 5'd0, 7'd0);
        wr1     = encode(OPC_RTYPE, 5'd1, 3'b000, 5'd0, 5'd0, 7'd0);
        wr2     = encode(OPC_RTYPE, 5'd2, 3'b000, 5'd0, 5'd0, 7'd0);
        lw1     = encode(OPC_LOAD, 5'd1, 3'b010, 5'd7, 5'd0, 7'd0);
        lw2     = encode(OPC_LOAD, 5'd2, 3'b010, 5'd7, 5'd0, 7'd0);
        lw4     = encode(OPC_LOAD, 5'd4, 3'b010, 5'd7, 5'd0, 7'd0);
        sw      = encode(OPC_STORE, 5'd8, 3'b010, 5'd1, 5'd2, 7'd0);
        lui     = {20'h12345, 5'd5, OPC_LUI, 2'b11};
        auipc   = {20'h00001, 5'd6, OPC_AUIPC, 2'b11};
        jal     = encode(OPC_JAL, 5'd1, 3'b000, 5'd0, 5'd0, 7'd0);
        jalr    = encode(OPC_JALR, 5'd1, 3'b000, 5'd5, 5'd16, 7'd0);
        beq     = encode(OPC_BRANCH, 5'd0, 3'b000, 5'd1, 5'd2, 7'd0);
        bne     = encode(OPC_BRANCH, 5'd0, 3'b001, 5'd1, 5'd2, 7'd0);
        blt     = encode(OPC_BRANCH, 5'd0, 3'b100, 5'd1, 5'd2, 7'd0);
        bge     = encode(OPC_BRANCH, 5'd0, 3'b101, 5'd1, 5'd2, 7'd0);
        bltu    = encode(OPC_BRANCH, 5'd0, 3'b110, 5'd1, 5'd2, 7'd0);
        bgeu    = encode(OPC_BRANCH, 5'd0, 3'b111, 5'd1, 5'd2, 7'd0);
        // Upper immediates
        add_entry(1'b1, lui, 32'h100, 32'hdeadbeef, 32'h11, 32'h12345000, 1'b0, '0, '0,
                  1'b0, 1'b0, 32'd0, 32'h12345000, 32'h11);
        add_entry(1'b1, auipc, 32'h104, 32'd0, 32'd0, 32'h1000, 1'b0, '0, '0,
                  1'b0, 1'b0, 32'd0, 32'h1104, 32'd0);
        // Forwarding priority and x0
        add_entry(1'b1, add3, 32'h108, 32'd1, 32'd2, 32'd0, 1'b0, {wr1, 32'd100},
                  {wr1, 32'd200}, 1'b0, 1'b0, 32'd0, 32'd102, 32'd2);
        add_entry(1'b1, add3, 32'h10c, 32'd1, 32'd2, 32'd0, 1'b0, {wr0, 32'd77},
                  {wr2, 32'd50}, 1'b0, 1'b0, 32'd0, 32'd51, 32'd50);
        add_entry(1'b1, add3_x0, 32'h110, 32'd0, 32'd2, 32'd0, 1'b0, {wr0, 32'd77},
                  {wr0, 32'd88}, 1'b0, 1'b0, 32'd0, 32'd2, 32'd2);
        add_entry(1'b1, sw, 32'h114, 32'h1000, 32'd2, 32'd8, 1'b0, {wr2, 32'h55}, '0,
                  1'b0, 1'b0, 32'd0, 32'h1008, 32'h55);
        // Load-use hazards, then the same instruction held with the load in WB
        add_entry(1'b1, add3, 32'h118, 32'd1, 32'd2, 32'd0, 1'b0, {lw4, 32'h3000}, '0,
                  1'b0, 1'b0, 32'd0, 32'd3, 32'd2);
        add_entry(1'b1, add3, 32'h11c, 32'd1, 32'd2, 32'd0, 1'b0, {lw2, 32'h2000}, '0,
                  1'b1, 1'b0, 32'd0, 32'd0, 32'd0);
        add_entry(1'b1, add3, 32'h11c, 32'd1, 32'd2, 32'd0, 1'b0, '0, {lw2, 32'h99},
                  1'b0, 1'b0, 32'd0, 32'h9a, 32'h99);
        add_entry(1'b1, addi3, 32'h120, 32'd1, 32'd0, 32'd5, 1'b0, {lw1, 32'h2000}, '0,
                  1'b1, 1'b0, 32'd0, 32'd0, 32'd0);
        add_entry(1'b1, addi3, 32'h120, 32'd1, 32'd0, 32'd5, 1'b0, '0, {lw1, 32'h40},
                  1'b0, 1'b0, 32'd0, 32'h45, 32'd0);
        // Branches at 0x200 with offset 0x40
        add_entry(1'b1, beq, 32'h200, 32'd5, 32'd5, 32'h40, 1'b0, '0, '0,
                  1'b0, 1'b1, 32'h240, 32'd0, 32'd5);
        add_entry(1'b1, bne, 32'h200, 32'd5, 32'd5, 32'h40, 1'b1, '0, '0,
                  1'b0, 1'b1, 32'h204, 32'd0, 32'd5);
        add_entry(1'b1, blt, 32'h200, 32'h7fffffff, 32'h80000000, 32'h40, 1'b1, '0, '0,
                  1'b0, 1'b1, 32'h204, 32'd0, 32'h80000000);
        add_entry(1'b1, bltu, 32'h200, 32'h7fffffff, 32'h80000000, 32'h40, 1'b0, '0, '0,
                  1'b0, 1'b1, 32'h240, 32'd0, 32'h80000000);
        add_entry(1'b1, bge, 32'h200, 32'h7fffffff, 32'h80000000, 32'h40, 1'b1, '0, '0,
                  1'b0, 1'b0, 32'd0, 32'd0, 32'h80000000);
        add_entry(1'b1, bgeu, 32'h200, 32'h7fffffff, 32'h80000000, 32'h40, 1'b0, '0, '0,
                  1'b0, 1'b0, 32'd0, 32'd0, 32'h80000000);
        add_entry(1'b1, blt, 32'h200, 32'hffffffff, 32'd0, 32'h40, 1'b0, '0, '0,
                  1'b0, 1'b1, 32'h240, 32'd0, 32'd0);
        add_entry(1'b1, bgeu, 32'h200, 32'hffffffff, 32'd0, 32'h40, 1'b1, '0, '0,
                  1'b0, 1'b0, 32'd0, 32'd0, 32'd0);
        add_entry(1'b1, beq, 32'h200, 32'd0, 32'd9, 32'h40, 1'b1, {wr1, 32'd9}, '0,
                  1'b0, 1'b0, 32'd0, 32'd0, 32'd9);
        // Jumps at 0x300
        add_entry(1'b1, jal, 32'h300, 32'd0, 32'd0, 32'h80, 1'b0, '0, '0,
                  1'b0, 1'b1, 32'h380, 32'h304, 32'd0);
        add_entry(1'b1, jal, 32'h300, 32'd0, 32'd0, 32'h80, 1'b1, '0, '0,
                  1'b0, 1'b0, 32'd0, 32'h304, 32'd0);
        add_entry(1'b1, jalr, 32'h300, 32'h1001, 32'd7, 32'h10, 1'b1, '0, '0,
                  1'b0, 1'b1, 32'h1010, 32'h304, 32'd7);
        // Invalid records
        add_entry(1'b0, beq, 32'h200, 32'd5, 32'd5, 32'h40, 1'b0, '0, '0,
                  1'b0, 1'b0, 32'd0, 32'd0, 32'd0);
        add_entry(1'b0, add3, 32'h124, 32'd1, 32'd2, 32'd0, 1'b0, {lw2, 32'h2000}, '0,
                  1'b0, 1'b0, 32'd0, 32'd0, 32'd0);
    endtask

    task automatic apply_vec(input vector_t v);
        logic exp_valid;
        exp_valid = v.id_ex.valid && !v.stall;
        @(negedge clk);
        id_ex   = v.id_ex;
        mem_fwd = v.mem_fwd;
        wb_fwd  = v.wb_fwd;
        #(CLK_PERIOD / 4);
        check_value("stall", 32'(stall), 32'(v.stall));
        check_value("redirect", 32'(redirect), 32'(v.redirect));
        check_value("flush", 32'(flush), 32'(v.redirect));
        if (v.redirect) begin
            check_value("redirect_pc", redirect_pc, v.redirect_pc);
        end
        @(posedge clk);
        #1;
        check_value("ex_mem.valid", 32'(ex_mem.valid), 32'(exp_valid));
        if (exp_valid) begin
            check_value("ex_mem.inst", ex_mem.inst, v.id_ex.inst);
            check_value("ex_mem.pc", ex_mem.pc, v.id_ex.pc);
            check_value("ex_mem.store_data", ex_mem.store_data, v.store_data);
            // Branch results are not architecturally defined
            if (v.id_ex.inst[6:2] != OPC_BRANCH) begin
                check_value("ex_mem.alu_result", ex_mem.alu_result, v.result);
            end
        end
    endtask

    task automatic run_sweep();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] op2;
        logic [31:0] inst;
        logic [2:0]  f3;
        logic        is_imm;
        logic        alt;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        for (int i = 0; i < SWEEP_LEN; i++) begin
            r      = lcg_next();
            a      = lcg_next();
            b      = lcg_next();
            f3     = r[30:28];
            is_imm = r[27];
            alt    = r[26] && (f3 == 3'b101 || (f3 == 3'b000 && !is_imm));
            rs1    = {r[23:20], 1'b1};
            rs2    = {r[19:16], 1'b1};
            rd     = r[15:11];
            if (is_imm) begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {21'd0, alt, 5'd0, b[4:0]};
                end else begin
                    imm = {{20{b[11]}}, b[11:0]};
                end
                inst = encode(OPC_ITYPE, rd, f3, rs1, imm[4:0], imm[11:5]);
                op2  = imm;
            end else begin
                imm  = 32'd0;
                inst = encode(OPC_RTYPE, rd, f3, rs1, rs2, {1'b0, alt, 5'd0});
                op2  = b;
            end
            apply_vec(make_vec(1'b1, inst, {20'd0, r[9:0], 2'b00}, a, b, imm, 1'b0, '0, '0,
                               1'b0, 1'b0, 32'd0, model_alu(is_imm, f3, alt, a, op2), b));
        end
    endtask

    initial begin
        lcg_state   = 32'd53437;
        errors      = 0;
        checks      = 0;
        table_built = 1'b0;
        rst         = 1'b1;
        id_ex       = '0;
        mem_fwd     = '0;
        wb_fwd      = '0;
        build_table();
        table_built = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("ex_mem.valid", 32'(ex_mem.valid), 32'd0);
        foreach (table_q[i]) begin
            apply_vec(table_q[i]);
        end
        run_sweep();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // One cycle per vector plus reset and margin
    initial begin
        wait (table_built);
        #((table_q.size() + SWEEP_LEN + 10) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/ex_stage_assertions.sv
`default_nettype none

module ex_stage_assertions (
    input logic            clk,
    input logic            rst,
    input rv_pkg::id_ex_t  id_ex,
    input logic            stall,
    input logic            redirect,
    input rv_pkg::ex_mem_t ex_mem
);

    // Reset or load-use stall leaves a bubble
    a_bubble: assert property (@(posedge clk) (rst || stall) |=> !ex_mem.valid)
        else $error("ex_mem.valid high in the cycle after reset or stall");

    a_idle: assert property (@(posedge clk) disable iff (rst)
                             !id_ex.valid |-> (!redirect && !stall))
        else $error("redirect or stall high for an invalid id_ex record");

endmodule

bind ex_stage ex_stage_assertions assertions_i (
    .clk      (clk),
    .rst      (rst),
    .id_ex    (id_ex),
    .stall    (stall),
    .redirect (redirect),
    .ex_mem   (ex_mem)
);

`default_nettype wire

// File: hdl/ex_stage.sv
`default_nettype none

module ex_stage (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::id_ex_t   id_ex,
    input  rv_pkg::fwd_src_t mem_fwd,
    input  rv_pkg::fwd_src_t wb_fwd,
    output logic             stall,
    output logic             redirect,
    output logic [31:0]      redirect_pc,
    output logic             flush,
    output rv_pkg::ex_mem_t  ex_mem
);

    import rv_pkg::*;

    ex_ctrl_t    ctrl;
    fwd_sel_e    fwd_a;
    fwd_sel_e    fwd_b;
    logic [31:0] op_a;
    logic [31:0] op_b;

    ex_control control_i (
        .id_ex   (id_ex),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd),
        .ctrl    (ctrl),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b),
        .stall   (stall)
    );

    ex_datapath datapath_i (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .id_ex   (id_ex),
        .ctrl    (ctrl),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd),
        .op_a    (op_a),
        .op_b    (op_b),
        .ex_mem  (ex_mem)
    );

    ex_branch_unit branch_i (
        .id_ex       (id_ex),
        .ctrl        (ctrl),
        .op_a        (op_a),
        .op_b        (op_b),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    // Younger instructions in IF and ID are squashed on every redirect
    assign flush = redirect;

endmodule

`default_nettype wire

// File: ex/ex_datapath.sv
`default_nettype none

module ex_datapath (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  rv_pkg::id_ex_t   id_ex,
    input  rv_pkg::ex_ctrl_t ctrl,
    input  rv_pkg::fwd_sel_e fwd_a,
    input  rv_pkg::fwd_sel_e fwd_b,
    input  rv_pkg::fwd_src_t mem_fwd,
    input  rv_pkg::fwd_src_t wb_fwd,
    output logic [31:0]      op_a,
    output logic [31:0]      op_b,
    output rv_pkg::ex_mem_t  ex_mem
);

    import rv_pkg::*;

    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_y;
    logic [4:0]  shamt;

    function automatic logic [31:0] fwd_mux(input fwd_sel_e sel, input logic [31:0] reg_val,
                                            input logic [31:0] mem_val,
                                            input logic [31:0] wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a = fwd_mux(fwd_a, id_ex.rs1_data, mem_fwd.result, wb_fwd.result);
    assign op_b = fwd_mux(fwd_b, id_ex.rs2_data, mem_fwd.result, wb_fwd.result);

    assign alu_a = (ctrl.a_sel == A_PC) ? id_ex.pc : op_a;

    always_comb begin
        case (ctrl.b_sel)
            B_IMM:   alu_b = id_ex.imm;
            B_FOUR:  alu_b = PC_INC;
            default: alu_b = op_b;
        endcase
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:    alu_y = alu_a - alu_b;
            ALU_AND:    alu_y = alu_a & alu_b;
            ALU_OR:     alu_y = alu_a | alu_b;
            ALU_XOR:    alu_y = alu_a ^ alu_b;
            ALU_SLL:    alu_y = alu_a << shamt;
            ALU_SRL:    alu_y = alu_a >> shamt;
            ALU_SRA:    alu_y = $signed(alu_a) >>> shamt;
            ALU_SLT:    alu_y = {31'd0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU:   alu_y = {31'd0, alu_a < alu_b};
            ALU_PASS_B: alu_y = alu_b;
            default:    alu_y = alu_a + alu_b;
        endcase
    end

    always_ff @(posedge clk) begin
        ex_mem.inst       <= id_ex.inst;
        ex_mem.pc         <= id_ex.pc;
        ex_mem.alu_result <= alu_y;
        ex_mem.store_data <= op_b;
        // Bubble while the load result is awaited
        if (rst || stall) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid;
        end
    end

endmodule

`default_nettype wire

// File: ex/ex_branch_unit.sv
`default_nettype none

module ex_branch_unit (
    input  rv_pkg::id_ex_t   id_ex,
    input  rv_pkg::ex_ctrl_t ctrl,
    input  logic [31:0]      op_a,
    input  logic [31:0]      op_b,
    output logic             redirect,
    output logic [31:0]      redirect_pc
);

    import rv_pkg::*;

    logic        eq;
    logic        lt;
    logic        cond;
    logic        taken;
    logic        mispredict;
    logic [31:0] target;

    assign eq = (op_a == op_b);
    assign lt = ctrl.cmp_unsigned ? (op_a < op_b) : ($signed(op_a) < $signed(op_b));

    always_comb begin
        case (id_ex.inst[14:12])
            FNC_BEQ:  cond = eq;
            FNC_BNE:  cond = !eq;
            FNC_BLT:  cond = lt;
            FNC_BGE:  cond = !lt;
            FNC_BLTU: cond = lt;
            FNC_BGEU: cond = !lt;
            default:  cond = 1'b0;
        endcase
    end

    assign taken = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && cond);

    assign target = ctrl.is_jalr ? ((op_a + id_ex.imm) & ~32'd1) : (id_ex.pc + id_ex.imm);

    // JALR target is never known at fetch
    assign mispredict = (taken != id_ex.pred_taken) || (ctrl.is_jalr && taken);

    assign redirect    = id_ex.valid && mispredict;
    assign redirect_pc = taken ? target : (id_ex.pc + PC_INC);

endmodule

`default_nettype wire

// File: ex/ex_control.sv
`default_nettype none

module ex_control (
    input  rv_pkg::id_ex_t   id_ex,
    input  rv_pkg::fwd_src_t mem_fwd,
    input  rv_pkg::fwd_src_t wb_fwd,
    output rv_pkg::ex_ctrl_t ctrl,
    output rv_pkg::fwd_sel_e fwd_a,
    output rv_pkg::fwd_sel_e fwd_b,
    output logic             stall
);

    import rv_pkg::*;

    logic [4:0] opc;
    logic [2:0] funct3;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       mem_hit_a;
    logic       mem_hit_b;
    logic       wb_hit_a;
    logic       wb_hit_b;
    logic       mem_is_load;

    // Shared by R-type and I-type; alt is bit 30 where it selects SUB or SRA
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            FNC_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            FNC_SLL:     return ALU_SLL;
            FNC_SLT:     return ALU_SLT;
            FNC_SLTU:    return ALU_SLTU;
            FNC_XOR:     return ALU_XOR;
            FNC_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            FNC_OR:      return ALU_OR;
            FNC_AND:     return ALU_AND;
            default:     return ALU_ADD;
        endcase
    endfunction

    assign opc    = id_ex.inst[6:2];
    assign funct3 = id_ex.inst[14:12];
    assign rs1    = id_ex.inst[19:15];
    assign rs2    = id_ex.inst[24:20];

    always_comb begin
        ctrl = '{a_sel: A_REG, b_sel: B_REG, alu_op: ALU_ADD, cmp_unsigned: 1'b0,
                 is_branch: 1'b0, is_jal: 1'b0, is_jalr: 1'b0};
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        case (opc)
            OPC_RTYPE: begin
                ctrl.alu_op       = arith_op(funct3, id_ex.inst[30]);
                ctrl.cmp_unsigned = (funct3 == FNC_SLTU);
                uses_rs2          = 1'b1;
            end
            OPC_ITYPE: begin
                ctrl.b_sel        = B_IMM;
                // ADDI with a negative immediate also has bit 30 set
                ctrl.alu_op       = arith_op(funct3,
                                             id_ex.inst[30] && funct3 == FNC_SRL_SRA);
                ctrl.cmp_unsigned = (funct3 == FNC_SLTU);
            end
            OPC_LOAD: begin
                ctrl.b_sel = B_IMM;
            end
            OPC_STORE: begin
                ctrl.b_sel = B_IMM;
                uses_rs2   = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.a_sel        = A_PC;
                ctrl.b_sel        = B_IMM;
                ctrl.is_branch    = 1'b1;
                ctrl.cmp_unsigned = id_ex.inst[13];
                uses_rs2          = 1'b1;
            end
            OPC_JAL: begin
                ctrl.a_sel = A_PC;
                ctrl.b_sel = B_FOUR;
                ctrl.is_jal = 1'b1;
                uses_rs1   = 1'b0;
            end
            OPC_JALR: begin
                ctrl.a_sel   = A_PC;
                ctrl.b_sel   = B_FOUR;
                ctrl.is_jalr = 1'b1;
            end
            OPC_LUI: begin
                ctrl.b_sel  = B_IMM;
                ctrl.alu_op = ALU_PASS_B;
                uses_rs1    = 1'b0;
            end
            OPC_AUIPC: begin
                ctrl.a_sel = A_PC;
                ctrl.b_sel = B_IMM;
                uses_rs1   = 1'b0;
            end
            default: begin
                uses_rs1 = 1'b0;
            end
        endcase
    end

    // writes_rd already excludes x0, so a match here never involves x0
    assign mem_hit_a   = writes_rd(mem_fwd.inst) && (mem_fwd.inst[11:7] == rs1);
    assign mem_hit_b   = writes_rd(mem_fwd.inst) && (mem_fwd.inst[11:7] == rs2);
    assign wb_hit_a    = writes_rd(wb_fwd.inst) && (wb_fwd.inst[11:7] == rs1);
    assign wb_hit_b    = writes_rd(wb_fwd.inst) && (wb_fwd.inst[11:7] == rs2);
    assign mem_is_load = (mem_fwd.inst[6:2] == OPC_LOAD);

    assign fwd_a = mem_hit_a ? FWD_MEM : (wb_hit_a ? FWD_WB : FWD_REG);
    assign fwd_b = mem_hit_b ? FWD_MEM : (wb_hit_b ? FWD_WB : FWD_REG);

    // Load data is not ready until WB
    assign stall = id_ex.valid && mem_is_load &&
                   ((uses_rs1 && mem_hit_a) || (uses_rs2 && mem_hit_b));

endmodule

`default_nettype wire

// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Opcode field, inst[6:2]
    localparam logic [4:0] OPC_RTYPE  = 5'b01100;
    localparam logic [4:0] OPC_ITYPE  = 5'b00100;
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;

    // Arithmetic funct3
    localparam logic [2:0] FNC_ADD_SUB = 3'b000;
    localparam logic [2:0] FNC_SLL     = 3'b001;
    localparam logic [2:0] FNC_SLT     = 3'b010;
    localparam logic [2:0] FNC_SLTU    = 3'b011;
    localparam logic [2:0] FNC_XOR     = 3'b100;
    localparam logic [2:0] FNC_SRL_SRA = 3'b101;
    localparam logic [2:0] FNC_OR      = 3'b110;
    localparam logic [2:0] FNC_AND     = 3'b111;

    // Branch funct3
    localparam logic [2:0] FNC_BEQ  = 3'b000;
    localparam logic [2:0] FNC_BNE  = 3'b001;
    localparam logic [2:0] FNC_BLT  = 3'b100;
    localparam logic [2:0] FNC_BGE  = 3'b101;
    localparam logic [2:0] FNC_BLTU = 3'b110;
    localparam logic [2:0] FNC_BGEU = 3'b111;

    localparam logic [4:0]  REG_X0 = 5'd0;
    localparam logic [31:0] PC_INC = 32'd4;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic {
        A_REG,
        A_PC
    } a_sel_e;

    typedef enum logic [1:0] {
        B_REG,
        B_IMM,
        B_FOUR
    } b_sel_e;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        logic        pred_taken;
    } id_ex_t;

    // Result of an instruction in MEM or WB; inst is zero when the stage is empty
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] result;
    } fwd_src_t;

    typedef struct packed {
        a_sel_e  a_sel;
        b_sel_e  b_sel;
        alu_op_e alu_op;
        logic    cmp_unsigned;
        logic    is_branch;
        logic    is_jal;
        logic    is_jalr;
    } ex_ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] alu_result;
        logic [31:0] store_data;
    } ex_mem_t;

    // Branches and stores have no rd; writes to x0 are dropped
    function automatic logic writes_rd(input logic [31:0] inst);
        logic [4:0] opc;
        opc = inst[6:2];
        if (inst[11:7] == REG_X0) begin
            return 1'b0;
        end
        case (opc)
            OPC_RTYPE, OPC_ITYPE, OPC_LOAD, OPC_JAL,
            OPC_JALR, OPC_LUI, OPC_AUIPC: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire
